//--- design/bridge_defs.svh
`ifndef BRIDGE_DEFS_SVH
`define BRIDGE_DEFS_SVH

// Bus widths shared by AHB and Wishbone sides
`define BRIDGE_ADDR_WIDTH 32
`define BRIDGE_DATA_WIDTH 32   // Strobe logic assumes four byte lanes

// Memory behind the bridge, in 32-bit words
// 256 words covers byte addresses 0 to 1023
`define BRIDGE_MEM_WORDS 256

// Default cycles of wait before the memory responds
`define BRIDGE_WAIT_STATES 1

`endif

//--- design/bridge_pkg.sv
`include "bridge_defs.svh"

package bridge_pkg;

    // AHB-Lite transfer type
    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } htrans_t;

    // Transfer size, only BYTE to WORD are legal on this bus
    typedef enum logic [2:0] {
        BYTE   = 3'b000,
        HALF   = 3'b001,
        WORD   = 3'b010,
        DWORD  = 3'b011,
        LINE4  = 3'b100,   // 128 bit
        LINE8  = 3'b101,   // 256 bit
        LINE16 = 3'b110,
        LINE32 = 3'b111
    } hsize_t;

    // AHB-Lite response, single bit
    typedef enum logic {
        OKAY  = 1'b0,
        ERROR = 1'b1
    } hresp_t;

    // One enable per byte lane
    typedef logic [`BRIDGE_DATA_WIDTH/8-1:0] strb_t;

endpackage

//--- design/ahb_wb_bridge.sv
`timescale 1ns/1ps
`include "bridge_defs.svh"

module ahb_wb_bridge (
    input  logic                          HCLK,
    input  logic                          HRESETn,

    // AHB-Lite slave side
    input  logic [`BRIDGE_ADDR_WIDTH-1:0] HADDR,
    input  bridge_pkg::htrans_t           HTRANS,
    input  logic                          HWRITE,
    input  bridge_pkg::hsize_t            HSIZE,
    input  logic [`BRIDGE_DATA_WIDTH-1:0] HWDATA,
    input  logic                          HREADY,
    output logic [`BRIDGE_DATA_WIDTH-1:0] HRDATA,
    output logic                          HREADYOUT,
    output bridge_pkg::hresp_t            HRESP,

    // Wishbone master side
    output logic                          wb_cyc,
    output logic                          wb_stb,
    output logic                          wb_we,
    output logic [`BRIDGE_ADDR_WIDTH-1:0] wb_adr,
    output bridge_pkg::strb_t             wb_sel,
    output logic [`BRIDGE_DATA_WIDTH-1:0] wb_dat_w,
    input  logic [`BRIDGE_DATA_WIDTH-1:0] wb_dat_r,
    input  logic                          wb_ack,
    input  logic                          wb_err
);

    typedef enum logic [1:0] {
        IDLE    = 2'b00,
        WB_WAIT = 2'b01,   // Data phase, Wishbone cycle pending or running
        ERR1    = 2'b10,   // First ERROR cycle, HREADYOUT low
        ERR2    = 2'b11    // Second ERROR cycle, HREADYOUT high
    } state_t;

    state_t            state;
    logic              trans_valid;
    logic              accept;
    logic              launch;
    logic              addr_legal;
    bridge_pkg::strb_t addr_strb;

    // Byte lanes for a size and low address bits
    // Zero result marks an illegal transfer
    function automatic bridge_pkg::strb_t lane_strb(
        input bridge_pkg::hsize_t size,
        input logic [1:0]         lo
    );
        bridge_pkg::strb_t s;
        s = '0;
        case (size)
            bridge_pkg::BYTE: begin
                s = bridge_pkg::strb_t'(4'b0001 << lo);
            end
            bridge_pkg::HALF: begin
                if (!lo[0]) begin
                    s = lo[1] ? 4'b1100 : 4'b0011;
                end
            end
            bridge_pkg::WORD: begin
                if (lo == 2'b00) begin
                    s = 4'b1111;
                end
            end
            default: s = '0;   // Wider than the bus
        endcase
        return s;
    endfunction

    assign trans_valid = (HTRANS == bridge_pkg::NONSEQ) || (HTRANS == bridge_pkg::SEQ);
    assign accept      = HREADY && HREADYOUT && trans_valid;
    assign addr_strb   = lane_strb(HSIZE, HADDR[1:0]);
    assign addr_legal  = |addr_strb;

    // First data-phase cycle, HWDATA is valid now
    assign launch = (state == WB_WAIT) && !wb_cyc;

    assign HREADYOUT = (state == IDLE) || (state == ERR2);
    assign HRESP     = ((state == ERR1) || (state == ERR2)) ? bridge_pkg::ERROR
                                                            : bridge_pkg::OKAY;

    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            state  <= IDLE;
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
        end else begin
            case (state)
                IDLE, ERR2: begin
                    // New address phase may overlap the last data cycle
                    if (accept) begin
                        state <= addr_legal ? WB_WAIT : ERR1;
                    end else begin
                        state <= IDLE;
                    end
                end
                WB_WAIT: begin
                    if (launch) begin
                        wb_cyc <= 1'b1;
                        wb_stb <= 1'b1;
                    end else if (wb_ack || wb_err) begin
                        wb_cyc <= 1'b0;
                        wb_stb <= 1'b0;
                        state  <= wb_err ? ERR1 : IDLE;
                    end
                end
                ERR1: state <= ERR2;
                default: state <= IDLE;
            endcase
        end
    end

    // Transfer attributes and data, held for the whole Wishbone cycle
    always_ff @(posedge HCLK) begin
        if (accept) begin
            wb_adr <= {HADDR[`BRIDGE_ADDR_WIDTH-1:2], 2'b00};   // Word aligned
            wb_we  <= HWRITE;
            wb_sel <= addr_strb;
        end
        if (launch) begin
            wb_dat_w <= HWDATA;
        end
        if (wb_cyc && wb_ack) begin
            HRDATA <= wb_dat_r;   // Visible when HREADYOUT rises
        end
    end

    a_stb_in_cyc: assert property (@(posedge HCLK) disable iff (!HRESETn)
        wb_stb |-> wb_cyc);

    // Slave sees a steady request until it responds
    a_wb_hold: assert property (@(posedge HCLK) disable iff (!HRESETn)
        wb_stb && !(wb_ack || wb_err) |=>
            wb_stb && $stable(wb_adr) && $stable(wb_sel) && $stable(wb_dat_w));

    // ERROR is one wait cycle then one ready cycle
    a_err_two_cycle: assert property (@(posedge HCLK) disable iff (!HRESETn)
        (HRESP == bridge_pkg::ERROR) && !HREADYOUT |=>
            (HRESP == bridge_pkg::ERROR) && HREADYOUT);

endmodule

//--- design/wb_sram.sv
`timescale 1ns/1ps
`include "bridge_defs.svh"

module wb_sram #(
    parameter int WAIT_STATES = `BRIDGE_WAIT_STATES
) (
    input  logic                          HCLK,
    input  logic                          HRESETn,
    input  logic                          wb_cyc,
    input  logic                          wb_stb,
    input  logic                          wb_we,
    input  logic [`BRIDGE_ADDR_WIDTH-1:0] wb_adr,
    input  bridge_pkg::strb_t             wb_sel,
    input  logic [`BRIDGE_DATA_WIDTH-1:0] wb_dat_w,
    output logic [`BRIDGE_DATA_WIDTH-1:0] wb_dat_r,
    output logic                          wb_ack,
    output logic                          wb_err
);

    localparam int CNT_W = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;
    localparam int IDX_W = $clog2(`BRIDGE_MEM_WORDS);
    localparam logic [`BRIDGE_ADDR_WIDTH-1:0] DEPTH = `BRIDGE_MEM_WORDS;

    logic [`BRIDGE_DATA_WIDTH-1:0] mem [`BRIDGE_MEM_WORDS];
    logic [`BRIDGE_ADDR_WIDTH-1:0] word_addr;
    logic [IDX_W-1:0]              mem_idx;
    logic [CNT_W-1:0]              wait_cnt;
    logic                          in_range;
    logic                          hit;

    assign word_addr = wb_adr >> 2;
    assign mem_idx   = word_addr[IDX_W-1:0];
    assign in_range  = word_addr < DEPTH;

    // Respond once the wait count is reached
    assign hit    = wb_cyc && wb_stb && (wait_cnt == CNT_W'(WAIT_STATES));
    assign wb_ack = hit && in_range;
    assign wb_err = hit && !in_range;

    assign wb_dat_r = in_range ? mem[mem_idx] : '0;

    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            wait_cnt <= '0;
        end else if (hit) begin
            wait_cnt <= '0;
        end else if (wb_cyc && wb_stb) begin
            wait_cnt <= wait_cnt + CNT_W'(1);
        end
    end

    // Byte lanes written at the ack edge
    always_ff @(posedge HCLK) begin
        if (wb_ack && wb_we) begin
            for (int b = 0; b < $bits(bridge_pkg::strb_t); b++) begin
                if (wb_sel[b]) begin
                    mem[mem_idx][8*b +: 8] <= wb_dat_w[8*b +: 8];
                end
            end
        end
    end

    a_ack_err_excl: assert property (@(posedge HCLK) disable iff (!HRESETn)
        !(wb_ack && wb_err));

    a_resp_in_cycle: assert property (@(posedge HCLK) disable iff (!HRESETn)
        (wb_ack || wb_err) |-> wb_cyc && wb_stb);

    // Master drops stb in the cycle after a response
    a_stb_drop: assert property (@(posedge HCLK) disable iff (!HRESETn)
        (wb_ack || wb_err) |=> !wb_stb);

endmodule

//--- design/ahb_wb_top.sv
`timescale 1ns/1ps
`include "bridge_defs.svh"

module ahb_wb_top (
    input  logic                          HCLK,
    input  logic                          HRESETn,
    input  logic [`BRIDGE_ADDR_WIDTH-1:0] HADDR,
    input  bridge_pkg::htrans_t           HTRANS,
    input  logic                          HWRITE,
    input  bridge_pkg::hsize_t            HSIZE,
    input  logic [`BRIDGE_DATA_WIDTH-1:0] HWDATA,
    input  logic                          HREADY,
    output logic [`BRIDGE_DATA_WIDTH-1:0] HRDATA,
    output logic                          HREADYOUT,
    output bridge_pkg::hresp_t            HRESP
);

    // Wishbone link between bridge and memory
    logic                          wb_cyc;
    logic                          wb_stb;
    logic                          wb_we;
    logic [`BRIDGE_ADDR_WIDTH-1:0] wb_adr;
    bridge_pkg::strb_t             wb_sel;
    logic [`BRIDGE_DATA_WIDTH-1:0] wb_dat_w;
    logic [`BRIDGE_DATA_WIDTH-1:0] wb_dat_r;
    logic                          wb_ack;
    logic                          wb_err;

    ahb_wb_bridge u_bridge (
        .HCLK      (HCLK),
        .HRESETn   (HRESETn),
        .HADDR     (HADDR),
        .HTRANS    (HTRANS),
        .HWRITE    (HWRITE),
        .HSIZE     (HSIZE),
        .HWDATA    (HWDATA),
        .HREADY    (HREADY),
        .HRDATA    (HRDATA),
        .HREADYOUT (HREADYOUT),
        .HRESP     (HRESP),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_sel    (wb_sel),
        .wb_dat_w  (wb_dat_w),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack),
        .wb_err    (wb_err)
    );

    wb_sram #(
        .WAIT_STATES (`BRIDGE_WAIT_STATES)
    ) u_sram (
        .HCLK     (HCLK),
        .HRESETn  (HRESETn),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_sel   (wb_sel),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .wb_err   (wb_err)
    );

endmodule

//--- bench/ahb_wb_tb.sv
`timescale 1ns/1ps
`include "bridge_defs.svh"

module ahb_wb_tb;

    logic                          HCLK;
    logic                          HRESETn;
    logic [`BRIDGE_ADDR_WIDTH-1:0] HADDR;
    bridge_pkg::htrans_t           HTRANS;
    logic                          HWRITE;
    bridge_pkg::hsize_t            HSIZE;
    logic [`BRIDGE_DATA_WIDTH-1:0] HWDATA;
    logic                          HREADY;
    logic [`BRIDGE_DATA_WIDTH-1:0] HRDATA;
    logic                          HREADYOUT;
    bridge_pkg::hresp_t            HRESP;

    // Transfer table, one entry per AHB transfer
    string                         t_name[$];
    logic                          t_write[$];
    logic [`BRIDGE_ADDR_WIDTH-1:0] t_addr[$];
    bridge_pkg::hsize_t            t_size[$];
    logic [`BRIDGE_DATA_WIDTH-1:0] t_wdata[$];
    bridge_pkg::hresp_t            t_resp[$];
    logic                          t_chk[$];

    logic [7:0] model [4*`BRIDGE_MEM_WORDS];   // Byte-addressed reference memory
    int         pass_cnt;
    int         fail_cnt;
    int         limit_ns;
    bit         table_ready;

    ahb_wb_top dut (
        .HCLK      (HCLK),
        .HRESETn   (HRESETn),
        .HADDR     (HADDR),
        .HTRANS    (HTRANS),
        .HWRITE    (HWRITE),
        .HSIZE     (HSIZE),
        .HWDATA    (HWDATA),
        .HREADY    (HREADY),
        .HRDATA    (HRDATA),
        .HREADYOUT (HREADYOUT),
        .HRESP     (HRESP)
    );

    assign HREADY = HREADYOUT;   // Single slave on the bus

    initial HCLK = 1'b0;
    always #5 HCLK = ~HCLK;

    task automatic add_entry(input string name, input logic wr,
                             input logic [`BRIDGE_ADDR_WIDTH-1:0] addr,
                             input bridge_pkg::hsize_t size,
                             input logic [`BRIDGE_DATA_WIDTH-1:0] data,
                             input bridge_pkg::hresp_t resp, input logic chk);
        t_name.push_back(name);
        t_write.push_back(wr);
        t_addr.push_back(addr);
        t_size.push_back(size);
        t_wdata.push_back(data);
        t_resp.push_back(resp);
        t_chk.push_back(chk);
    endtask

    task automatic build_table();
        logic [`BRIDGE_ADDR_WIDTH-1:0] addr;
        logic [`BRIDGE_DATA_WIDTH-1:0] data;
        add_entry("wr_word_0", 1'b1, 32'h000, bridge_pkg::WORD, 32'hdead_beef, bridge_pkg::OKAY, 0);
        add_entry("rd_word_0", 1'b0, 32'h000, bridge_pkg::WORD, '0, bridge_pkg::OKAY, 1);
        // Byte lanes merged into one word
        add_entry("wr_byte_10", 1'b1, 32'h010, bridge_pkg::BYTE, 32'h0000_00a1, bridge_pkg::OKAY, 0);
        add_entry("wr_byte_11", 1'b1, 32'h011, bridge_pkg::BYTE, 32'h0000_b200, bridge_pkg::OKAY, 0);
        add_entry("wr_byte_12", 1'b1, 32'h012, bridge_pkg::BYTE, 32'h00c3_0000, bridge_pkg::OKAY, 0);
        add_entry("wr_byte_13", 1'b1, 32'h013, bridge_pkg::BYTE, 32'hd400_0000, bridge_pkg::OKAY, 0);
        add_entry("rd_word_10", 1'b0, 32'h010, bridge_pkg::WORD, '0, bridge_pkg::OKAY, 1);
        add_entry("wr_half_14", 1'b1, 32'h014, bridge_pkg::HALF, 32'h0000_5566, bridge_pkg::OKAY, 0);
        add_entry("wr_half_16", 1'b1, 32'h016, bridge_pkg::HALF, 32'h7788_0000, bridge_pkg::OKAY, 0);
        add_entry("rd_word_14", 1'b0, 32'h014, bridge_pkg::WORD, '0, bridge_pkg::OKAY, 1);
        add_entry("rd_byte_16", 1'b0, 32'h016, bridge_pkg::BYTE, '0, bridge_pkg::OKAY, 1);
        // Illegal size and alignment leave memory alone
        add_entry("wr_word_20", 1'b1, 32'h020, bridge_pkg::WORD, 32'h1122_3344, bridge_pkg::OKAY, 0);
        add_entry("wr_half_mis", 1'b1, 32'h021, bridge_pkg::HALF, '1, bridge_pkg::ERROR, 0);
        add_entry("wr_dword", 1'b1, 32'h020, bridge_pkg::DWORD, '1, bridge_pkg::ERROR, 0);
        add_entry("rd_half_mis", 1'b0, 32'h023, bridge_pkg::HALF, '0, bridge_pkg::ERROR, 0);
        add_entry("rd_word_20", 1'b0, 32'h020, bridge_pkg::WORD, '0, bridge_pkg::OKAY, 1);
        add_entry("wr_oob", 1'b1, 4*`BRIDGE_MEM_WORDS, bridge_pkg::WORD, '1, bridge_pkg::ERROR, 0);
        add_entry("rd_oob", 1'b0, 4*`BRIDGE_MEM_WORDS + 'h100, bridge_pkg::WORD, '0,
                  bridge_pkg::ERROR, 0);
        add_entry("rd_word_0b", 1'b0, 32'h000, bridge_pkg::WORD, '0, bridge_pkg::OKAY, 1);
        for (int k = 0; k < 32; k++) begin
            addr = ($urandom % `BRIDGE_MEM_WORDS) * 4;
            data = $urandom;
            add_entry($sformatf("rnd_wr_%0d", k), 1'b1, addr, bridge_pkg::WORD, data,
                      bridge_pkg::OKAY, 0);
            add_entry($sformatf("rnd_rd_%0d", k), 1'b0, addr, bridge_pkg::WORD, '0,
                      bridge_pkg::OKAY, 1);
        end
    endtask

    // Active byte lanes of a legal transfer
    function automatic logic [31:0] lane_mask(input logic [31:0] addr,
                                              input bridge_pkg::hsize_t size);
        logic [31:0] m;
        int          first;
        int          count;
        m     = '0;
        first = int'(addr[1:0]);
        count = 1 << int'(size);
        for (int b = 0; b < 4; b++) begin
            if (b >= first && b < first + count) m[8*b +: 8] = 8'hff;
        end
        return m;
    endfunction

    function automatic logic [31:0] model_word(input logic [31:0] addr);
        int base;
        base = int'(addr) & ~3;
        return {model[base+3], model[base+2], model[base+1], model[base]};
    endfunction

    task automatic check_resp(input string name, input bridge_pkg::hresp_t exp,
                              input bridge_pkg::hresp_t act, output bit ok);
        ok = (exp == act);
        if (!ok) $display("ERR %s expected %s actual %s", name, exp.name(), act.name());
    endtask

    task automatic check_data(input string name, input logic [`BRIDGE_DATA_WIDTH-1:0] exp,
                              input logic [`BRIDGE_DATA_WIDTH-1:0] act, output bit ok);
        ok = (exp === act);
        if (!ok) $display("ERR %s expected %08h actual %08h", name, exp, act);
    endtask

    // Called in the last cycle of a data phase, outputs are settled
    task automatic finish_transfer(input int i);
        bit          ok;
        logic [31:0] mask;
        int          base;
        mask = lane_mask(t_addr[i], t_size[i]);
        base = int'(t_addr[i]) & ~3;
        check_resp(t_name[i], t_resp[i], HRESP, ok);
        if (t_write[i] && t_resp[i] == bridge_pkg::OKAY) begin
            for (int b = 0; b < 4; b++) begin
                if (mask[8*b]) model[base+b] = t_wdata[i][8*b +: 8];
            end
        end
        if (ok && t_chk[i]) begin
            check_data(t_name[i], model_word(t_addr[i]) & mask, HRDATA & mask, ok);
        end
        if (ok) begin
            pass_cnt++;
            $display("ok   %s", t_name[i]);
        end else begin
            fail_cnt++;
        end
    endtask

    initial begin
        int ap;   // Entry in address phase
        int dp;   // Entry in data phase
        int next;
        bit take;
        bit ok;
        HRESETn  = 1'b0;
        HADDR    = '0;
        HTRANS   = bridge_pkg::IDLE;
        HWRITE   = 1'b0;
        HSIZE    = bridge_pkg::WORD;
        HWDATA   = '0;
        pass_cnt = 0;
        fail_cnt = 0;
        void'($urandom(32'h8faa_0f43));
        build_table();
        limit_ns    = t_name.size() * (`BRIDGE_WAIT_STATES + 6) * 10 * 2;
        table_ready = 1'b1;
        repeat (4) @(posedge HCLK);
        HRESETn <= 1'b1;
        @(negedge HCLK);
        check_resp("reset_state", bridge_pkg::OKAY, HRESP, ok);
        if (!HREADYOUT) $display("reset_state: HREADYOUT is low after reset");
        if (ok && HREADYOUT) begin
            pass_cnt++;
            $display("ok   reset_state");
        end else begin
            fail_cnt++;
        end
        ap   = -1;
        dp   = -1;
        next = 0;
        while (ap >= 0 || dp >= 0 || next < t_name.size()) begin
            @(negedge HCLK);
            take = HREADYOUT;   // Coming edge ends a data phase and takes an address
            if (take) begin
                if (dp >= 0) finish_transfer(dp);
                dp = ap;
                ap = -1;
                if (next < t_name.size()) begin
                    ap = next;
                    next++;
                end
            end
            @(posedge HCLK);
            if (take) begin
                if (dp >= 0) HWDATA <= t_wdata[dp];
                if (ap >= 0) begin
                    HADDR  <= t_addr[ap];
                    HWRITE <= t_write[ap];
                    HSIZE  <= t_size[ap];
                    HTRANS <= bridge_pkg::NONSEQ;
                end else begin
                    HTRANS <= bridge_pkg::IDLE;
                end
            end
        end
        $display("tests: %0d passed, %0d failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        wait (table_ready);
        #(limit_ns);
        $display("watchdog: transfers did not complete");
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

//--- project.f
+incdir+design
design/bridge_pkg.sv
design/ahb_wb_bridge.sv
design/wb_sram.sv
design/ahb_wb_top.sv
bench/ahb_wb_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the AHB to Wishbone bridge testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --assert \
    -f project.f \
    --top-module ahb_wb_tb \
    -o ahb_wb_sim

./obj_dir/ahb_wb_sim 2>&1 | tee sim.log

if grep -q "RESULT: PASS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi
